// File: files.f
hw/spec_pkg.sv
hw/spec_decode.sv
hw/spec_execute.sv
hw/spec_api.sv
hw/spec_state.sv
hw/spec_data_ram.sv
hw/spec_top.sv
verification/spec_tb.sv

// File: hw/spec_api.sv
////////////////////////////////////////
// Spec API wrapper.
// Feeds state into the specification and
// flattens its effects to named outputs.
////////////////////////////////////////

`timescale 1ns/1ps

module spec_api (
    input  spec_pkg::decoded_t   op_i,
    input  logic [31:0]          pc_i,
    input  logic [31:0]          regs_i [1:31],
    input  spec_pkg::csr_state_t csr_i,
    input  logic [31:0]          mem_rdata_i,
    output logic                 wx_en_o,
    output logic [4:0]           wx_addr_o,
    output logic [31:0]          wx_o,
    output logic [31:0]          pc_o,
    output spec_pkg::csr_state_t csr_o,
    output logic                 mem_read_o,
    output logic                 mem_write_o,
    output logic [31:0]          mem_addr_o,
    output logic [31:0]          mem_wdata_o,
    output logic [3:0]           mem_be_o,
    output logic                 trap_o,
    output logic [31:0]          cause_o
);
    import spec_pkg::*;

    wb_t      wb;
    mem_req_t mem;

    spec_execute u_spec (
        .op_i       (op_i),
        .pc_i       (pc_i),
        .regs_i     (regs_i),
        .csr_i      (csr_i),
        .mem_rdata_i(mem_rdata_i),
        .wb_o       (wb),
        .next_pc_o  (pc_o),
        .csr_o      (csr_o),
        .mem_o      (mem),
        .trap_o     (trap_o),
        .cause_o    (cause_o)
    );

    // Register file effect.
    assign wx_en_o   = wb.we;
    assign wx_addr_o = wb.addr;
    assign wx_o      = wb.data;

    // Data memory effect.
    assign mem_read_o  = mem.re;
    assign mem_write_o = mem.we;
    assign mem_addr_o  = mem.addr;
    assign mem_wdata_o = mem.wdata;
    assign mem_be_o    = mem.be;

endmodule

// File: hw/spec_data_ram.sv
////////////////////////////////////////
// Data RAM.
// Combinational read, byte-enabled write.
////////////////////////////////////////

`timescale 1ns/1ps

module spec_data_ram #(
    parameter int unsigned RamWords = 256
) (
    input  logic        clk_i,
    input  logic        we_i,
    input  logic [31:0] addr_i,
    input  logic [31:0] wdata_i,
    input  logic [3:0]  be_i,
    output logic [31:0] rdata_o
);

    logic [31:0] mem [RamWords];
    logic [31:0] idx;

    // Word address wraps on the RAM depth.
    assign idx     = addr_i % RamWords;
    assign rdata_o = mem[idx];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (be_i[b]) mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
            end
        end
    end

endmodule

// File: hw/spec_decode.sv
////////////////////////////////////////
// Instruction decoder.
// Raw RV32 word to decoded op and immediate.
////////////////////////////////////////

`timescale 1ns/1ps

module spec_decode (
    input  logic [31:0]         insn_i,
    output spec_pkg::decoded_t  op_o
);
    import spec_pkg::*;

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
    localparam logic [31:0] MRET_WORD = 32'h3020_0073;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = insn_i[6:0];
    assign funct3 = insn_i[14:12];
    assign funct7 = insn_i[31:25];

    // Sign-extended immediates for each format.
    assign imm_i = {{20{insn_i[31]}}, insn_i[31:20]};
    assign imm_s = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
    assign imm_b = {{19{insn_i[31]}}, insn_i[31], insn_i[7], insn_i[30:25],
                    insn_i[11:8], 1'b0};
    assign imm_u = {insn_i[31:12], 12'b0};
    assign imm_j = {{11{insn_i[31]}}, insn_i[31], insn_i[19:12], insn_i[20],
                    insn_i[30:21], 1'b0};

    always_comb begin
        op_o     = '0;
        op_o.op  = OP_ILLEGAL;
        op_o.rd  = insn_i[11:7];
        op_o.rs1 = insn_i[19:15];
        op_o.rs2 = insn_i[24:20];
        op_o.csr = insn_i[31:20];
        op_o.imm = imm_i;
        unique case (opcode)
            OPC_OP_IMM: if (funct3 == 3'b000) op_o.op = OP_ADDI;
            OPC_OP: begin
                if (funct3 == 3'b000 && funct7 == 7'b0000000) op_o.op = OP_ADD;
                if (funct3 == 3'b000 && funct7 == 7'b0100000) op_o.op = OP_SUB;
            end
            OPC_LUI: begin
                op_o.op  = OP_LUI;
                op_o.imm = imm_u;
            end
            OPC_LOAD: if (funct3 == 3'b010) op_o.op = OP_LW;
            OPC_STORE: begin
                if (funct3 == 3'b010) op_o.op = OP_SW;
                op_o.imm = imm_s;
            end
            OPC_BRANCH: begin
                if (funct3 == 3'b000) op_o.op = OP_BEQ;
                op_o.imm = imm_b;
            end
            OPC_JAL: begin
                op_o.op  = OP_JAL;
                op_o.imm = imm_j;
            end
            OPC_SYSTEM: begin
                if (funct3 == 3'b001) op_o.op = OP_CSRRW;
                else if (insn_i == MRET_WORD) op_o.op = OP_MRET;
            end
            default: op_o.op = OP_ILLEGAL;
        endcase
    end

endmodule

// File: hw/spec_execute.sv
////////////////////////////////////////
// Specification of one instruction step.
// Computes writeback, next pc, memory
// request, CSR update and trap.
////////////////////////////////////////

`timescale 1ns/1ps

module spec_execute (
    input  spec_pkg::decoded_t   op_i,
    input  logic [31:0]          pc_i,
    input  logic [31:0]          regs_i [1:31],
    input  spec_pkg::csr_state_t csr_i,
    input  logic [31:0]          mem_rdata_i,
    output spec_pkg::wb_t        wb_o,
    output logic [31:0]          next_pc_o,
    output spec_pkg::csr_state_t csr_o,
    output spec_pkg::mem_req_t   mem_o,
    output logic                 trap_o,
    output logic [31:0]          cause_o
);
    import spec_pkg::*;

    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] ea;
    logic [31:0] mstatus_word;
    logic [31:0] csr_old;
    logic        csr_ok;

    // x0 is hardwired to zero.
    assign rs1_val = (op_i.rs1 == 5'd0) ? 32'd0 : regs_i[op_i.rs1];
    assign rs2_val = (op_i.rs2 == 5'd0) ? 32'd0 : regs_i[op_i.rs2];
    assign ea      = rs1_val + op_i.imm;

    assign mstatus_word = {19'd0, csr_i.mstatus.mpp, 3'd0, csr_i.mstatus.mpie,
                           3'd0, csr_i.mstatus.mie, 3'd0};

    always_comb begin
        csr_ok  = 1'b1;
        csr_old = 32'd0;
        unique case (op_i.csr)
            CSR_MSTATUS:  csr_old = mstatus_word;
            CSR_MTVEC:    csr_old = csr_i.mtvec;
            CSR_MSCRATCH: csr_old = csr_i.mscratch;
            CSR_MEPC:     csr_old = csr_i.mepc;
            CSR_MCAUSE:   csr_old = csr_i.mcause;
            default:      csr_ok  = 1'b0;
        endcase
    end

    always_comb begin
        wb_o      = '{we: 1'b0, addr: op_i.rd, data: 32'd0};
        next_pc_o = pc_i + 32'd4;
        csr_o     = csr_i;
        mem_o     = '0;
        trap_o    = 1'b0;
        cause_o   = 32'd0;
        unique case (op_i.op)
            OP_ADDI: wb_o = '{we: 1'b1, addr: op_i.rd, data: rs1_val + op_i.imm};
            OP_ADD:  wb_o = '{we: 1'b1, addr: op_i.rd, data: rs1_val + rs2_val};
            OP_SUB:  wb_o = '{we: 1'b1, addr: op_i.rd, data: rs1_val - rs2_val};
            OP_LUI:  wb_o = '{we: 1'b1, addr: op_i.rd, data: op_i.imm};
            OP_LW: begin
                mem_o.re   = 1'b1;
                mem_o.addr = {2'b00, ea[31:2]};
                wb_o       = '{we: 1'b1, addr: op_i.rd, data: mem_rdata_i};
                trap_o     = (ea[1:0] != 2'b00);
                cause_o    = CAUSE_LOAD_MIS;
            end
            OP_SW: begin
                mem_o   = '{re: 1'b0, we: 1'b1, addr: {2'b00, ea[31:2]},
                            wdata: rs2_val, be: 4'hf};
                trap_o  = (ea[1:0] != 2'b00);
                cause_o = CAUSE_STORE_MIS;
            end
            OP_BEQ: if (rs1_val == rs2_val) next_pc_o = pc_i + op_i.imm;
            OP_JAL: begin
                wb_o      = '{we: 1'b1, addr: op_i.rd, data: pc_i + 32'd4};
                next_pc_o = pc_i + op_i.imm;
            end
            OP_CSRRW: begin
                wb_o = '{we: 1'b1, addr: op_i.rd, data: csr_old};
                unique case (op_i.csr)
                    CSR_MSTATUS: csr_o.mstatus = '{mie: rs1_val[3], mpie: rs1_val[7],
                                                   mpp: rs1_val[12:11]};
                    CSR_MTVEC:    csr_o.mtvec    = {rs1_val[31:2], 2'b00};
                    CSR_MSCRATCH: csr_o.mscratch = rs1_val;
                    CSR_MEPC:     csr_o.mepc     = rs1_val;
                    CSR_MCAUSE:   csr_o.mcause   = rs1_val;
                    default:      csr_o          = csr_i;
                endcase
                trap_o  = !csr_ok;
                cause_o = CAUSE_ILLEGAL;
            end
            OP_MRET: begin
                csr_o.mstatus.mie  = csr_i.mstatus.mpie;
                csr_o.mstatus.mpie = 1'b1;
                next_pc_o          = csr_i.mepc;
            end
            default: begin
                trap_o  = 1'b1;
                cause_o = CAUSE_ILLEGAL;
            end
        endcase

        if (trap_o) begin
            wb_o.we   = 1'b0;
            mem_o     = '0;
            csr_o     = csr_i;
            csr_o.mepc   = pc_i;
            csr_o.mcause = cause_o;
            csr_o.mstatus = '{mie: 1'b0, mpie: csr_i.mstatus.mie, mpp: 2'b11};
            next_pc_o = csr_i.mtvec;
        end else begin
            cause_o = 32'd0;
        end
        if (op_i.rd == 5'd0) wb_o.we = 1'b0;
    end

endmodule

// File: hw/spec_pkg.sv
////////////////////////////////////////
// Spec package.
// Shared types and constants of the RV32
// machine-mode reference stepper.
////////////////////////////////////////

package spec_pkg;

    typedef enum logic [3:0] {
        OP_ADDI,
        OP_ADD,
        OP_SUB,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_JAL,
        OP_CSRRW,
        OP_MRET,
        OP_ILLEGAL
    } op_e;

    typedef struct packed {
        op_e         op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        logic [11:0] csr;
    } decoded_t;

    // Lives at mstatus bits 3, 7 and 12:11.
    typedef struct packed {
        logic       mie;
        logic       mpie;
        logic [1:0] mpp;
    } mstatus_t;

    typedef struct packed {
        mstatus_t    mstatus;
        logic [31:0] mepc;
        logic [31:0] mcause;
        logic [31:0] mtvec;
        logic [31:0] mscratch;
    } csr_state_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  addr;
        logic [31:0] data;
    } wb_t;

    // Addr is a word address, byte address shifted right by two.
    typedef struct packed {
        logic        re;
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] next_pc;
        wb_t         wb;
        mem_req_t    mem;
        logic        trap;
        logic [31:0] cause;
    } retire_t;

    localparam logic [11:0] CSR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;

    localparam logic [31:0] CAUSE_ILLEGAL   = 32'd2;
    localparam logic [31:0] CAUSE_LOAD_MIS  = 32'd4;
    localparam logic [31:0] CAUSE_STORE_MIS = 32'd6;

endpackage

// File: hw/spec_state.sv
////////////////////////////////////////
// Architectural state.
// Pc, x1..x31 and machine CSRs, loaded
// on commit.
////////////////////////////////////////

`timescale 1ns/1ps

module spec_state #(
    parameter logic [31:0] BootAddr = 32'h0000_0080
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 commit_i,
    input  logic                 wx_en_i,
    input  logic [4:0]           wx_addr_i,
    input  logic [31:0]          wx_i,
    input  logic [31:0]          next_pc_i,
    input  spec_pkg::csr_state_t csr_i,
    output logic [31:0]          pc_o,
    output logic [31:0]          regs_o [1:31],
    output spec_pkg::csr_state_t csr_o
);
    import spec_pkg::*;

    logic [31:0] pc_q;
    logic [31:0] regs_q [1:31];
    csr_state_t  csr_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q  <= BootAddr;
            csr_q <= '0;
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= 32'd0;
            end
        end else if (commit_i) begin
            pc_q  <= next_pc_i;
            csr_q <= csr_i;
            // Enable is already clear for x0.
            if (wx_en_i) begin
                regs_q[wx_addr_i] <= wx_i;
            end
        end
    end

    assign pc_o   = pc_q;
    assign regs_o = regs_q;
    assign csr_o  = csr_q;

endmodule

// File: hw/spec_top.sv
////////////////////////////////////////
// Reference stepper top level.
// One instruction in, one retire record out.
////////////////////////////////////////

`timescale 1ns/1ps

module spec_top #(
    parameter logic [31:0] BootAddr = 32'h0000_0080,
    parameter int unsigned RamWords = 256
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              insn_valid_i,
    input  logic [31:0]       insn_i,
    output logic              insn_ready_o,
    output logic              retire_valid_o,
    output spec_pkg::retire_t retire_o,
    input  logic              retire_ready_i
);
    import spec_pkg::*;

    decoded_t    dec;
    csr_state_t  csr_cur, csr_nxt;
    logic [31:0] pc_cur, pc_nxt;
    logic [31:0] regs [1:31];
    logic        wx_en, mem_re, mem_we, trap;
    logic [4:0]  wx_addr;
    logic [31:0] wx, mem_addr, mem_wdata, mem_rdata, cause;
    logic [3:0]  mem_be;
    logic        accept;
    logic        pending_q;
    retire_t     retire_q;

    assign insn_ready_o   = !pending_q;
    assign accept         = insn_valid_i && insn_ready_o;
    assign retire_valid_o = pending_q;
    assign retire_o       = retire_q;

    spec_decode u_decode (
        .insn_i(insn_i),
        .op_o  (dec)
    );

    spec_api u_api (
        .op_i       (dec),
        .pc_i       (pc_cur),
        .regs_i     (regs),
        .csr_i      (csr_cur),
        .mem_rdata_i(mem_rdata),
        .wx_en_o    (wx_en),
        .wx_addr_o  (wx_addr),
        .wx_o       (wx),
        .pc_o       (pc_nxt),
        .csr_o      (csr_nxt),
        .mem_read_o (mem_re),
        .mem_write_o(mem_we),
        .mem_addr_o (mem_addr),
        .mem_wdata_o(mem_wdata),
        .mem_be_o   (mem_be),
        .trap_o     (trap),
        .cause_o    (cause)
    );

    spec_state #(
        .BootAddr(BootAddr)
    ) u_state (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .commit_i (accept),
        .wx_en_i  (wx_en),
        .wx_addr_i(wx_addr),
        .wx_i     (wx),
        .next_pc_i(pc_nxt),
        .csr_i    (csr_nxt),
        .pc_o     (pc_cur),
        .regs_o   (regs),
        .csr_o    (csr_cur)
    );

    spec_data_ram #(
        .RamWords(RamWords)
    ) u_ram (
        .clk_i  (clk_i),
        .we_i   (accept && mem_we),
        .addr_i (mem_addr),
        .wdata_i(mem_wdata),
        .be_i   (mem_be),
        .rdata_o(mem_rdata)
    );

    // Pending until the retire handshake.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q <= 1'b0;
        end else if (accept) begin
            pending_q <= 1'b1;
        end else if (retire_ready_i) begin
            pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            retire_q.pc      <= pc_cur;
            retire_q.next_pc <= pc_nxt;
            retire_q.wb      <= '{we: wx_en, addr: wx_addr, data: wx};
            retire_q.mem     <= '{re: mem_re, we: mem_we, addr: mem_addr,
                                  wdata: mem_wdata, be: mem_be};
            retire_q.trap    <= trap;
            retire_q.cause   <= cause;
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then check the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module spec_tb -o spec_tb_sim

./obj_dir/spec_tb_sim 2>&1 | tee sim.log

if grep -q "TB PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: verification/spec_tb.sv
////////////////////////////////////////
// Testbench for the reference stepper.
// Drives a fixed program, predicts each
// retire record and checks it.
////////////////////////////////////////

`timescale 1ns/1ps

module spec_tb;
    import spec_pkg::*;

    localparam logic [31:0] BootAddr = 32'h0000_0080;

    logic        clk_i          = 1'b0;
    logic        rst_i          = 1'b1;
    logic        insn_valid_i   = 1'b0;
    logic [31:0] insn_i         = 32'd0;
    logic        retire_ready_i = 1'b0;
    logic        insn_ready_o;
    logic        retire_valid_o;
    retire_t     retire_o;
    integer      seed           = 32'hc68c15c2;

    // Model state.
    logic [31:0] m_pc = BootAddr;
    logic [31:0] m_regs [0:31];
    logic [31:0] m_mem [0:255];
    logic [31:0] m_mepc = 32'd0;
    logic [31:0] m_mcause = 32'd0;
    logic [31:0] m_mtvec = 32'd0;
    logic [31:0] m_mscratch = 32'd0;
    logic        m_mie = 1'b0;
    logic        m_mpie = 1'b0;
    logic [1:0]  m_mpp = 2'b00;
    retire_t     want = '0;

    spec_top UUT (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .insn_valid_i  (insn_valid_i),
        .insn_i        (insn_i),
        .insn_ready_o  (insn_ready_o),
        .retire_valid_o(retire_valid_o),
        .retire_o      (retire_o),
        .retire_ready_i(retire_ready_i)
    );

    always #5 clk_i = ~clk_i;

    // Random back-pressure, ready about three cycles in four.
    always @(posedge clk_i) begin
        retire_ready_i <= ($random(seed) & 3) != 0;
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp_v);
        stop_on_error($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp_v));
    endtask

    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [4:0] rd);
        return {f7, rs2, rs1, 3'd0, rd, 7'h33};
    endfunction

    function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'd0, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] jtype(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    // Applies the ISA rules to the model and sets the expected record.
    task automatic predict(input logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ea;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] cause;
        logic [6:0]  opc;
        logic [2:0]  f3;
        retire_t     r;
        a = m_regs[w[19:15]];
        b = m_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        opc = w[6:0];
        f3 = w[14:12];
        cause = 32'd0;
        r = '0;
        r.pc = m_pc;
        r.next_pc = m_pc + 32'd4;
        r.wb.addr = w[11:7];
        if (w == 32'h3020_0073) begin
            m_mie = m_mpie;
            m_mpie = 1'b1;
            r.next_pc = m_mepc;
        end else if (opc == 7'h13 && f3 == 3'd0) begin
            r.wb = '{we: 1'b1, addr: w[11:7], data: a + imm_i};
        end else if (opc == 7'h33 && f3 == 3'd0 && w[31:25] == 7'h00) begin
            r.wb = '{we: 1'b1, addr: w[11:7], data: a + b};
        end else if (opc == 7'h33 && f3 == 3'd0 && w[31:25] == 7'h20) begin
            r.wb = '{we: 1'b1, addr: w[11:7], data: a - b};
        end else if (opc == 7'h37) begin
            r.wb = '{we: 1'b1, addr: w[11:7], data: {w[31:12], 12'd0}};
        end else if (opc == 7'h03 && f3 == 3'd2) begin
            ea = a + imm_i;
            r.mem.re = 1'b1;
            r.mem.addr = {2'b00, ea[31:2]};
            r.wb = '{we: 1'b1, addr: w[11:7], data: m_mem[ea[9:2]]};
            if (ea[1:0] != 2'b00) cause = CAUSE_LOAD_MIS;
        end else if (opc == 7'h23 && f3 == 3'd2) begin
            ea = a + imm_s;
            r.mem = '{re: 1'b0, we: 1'b1, addr: {2'b00, ea[31:2]}, wdata: b, be: 4'hf};
            if (ea[1:0] != 2'b00) cause = CAUSE_STORE_MIS;
            else m_mem[ea[9:2]] = b;
        end else if (opc == 7'h63 && f3 == 3'd0) begin
            if (a == b) r.next_pc = m_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end else if (opc == 7'h6f) begin
            r.wb = '{we: 1'b1, addr: w[11:7], data: m_pc + 32'd4};
            r.next_pc = m_pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end else if (opc == 7'h73 && f3 == 3'd1) begin
            r.wb.we = 1'b1;
            case (w[31:20])
                CSR_MSTATUS: begin
                    r.wb.data = (32'(m_mpp) << 11) | (32'(m_mpie) << 7) | (32'(m_mie) << 3);
                    m_mie = a[3];
                    m_mpie = a[7];
                    m_mpp = a[12:11];
                end
                CSR_MTVEC: begin
                    r.wb.data = m_mtvec;
                    m_mtvec = {a[31:2], 2'b00};
                end
                CSR_MSCRATCH: begin
                    r.wb.data = m_mscratch;
                    m_mscratch = a;
                end
                CSR_MEPC: begin
                    r.wb.data = m_mepc;
                    m_mepc = a;
                end
                CSR_MCAUSE: begin
                    r.wb.data = m_mcause;
                    m_mcause = a;
                end
                default: cause = CAUSE_ILLEGAL;
            endcase
        end else begin
            cause = CAUSE_ILLEGAL;
        end
        if (cause != 32'd0) begin
            r.trap = 1'b1;
            r.cause = cause;
            r.wb.we = 1'b0;
            r.mem = '0;
            m_mepc = m_pc;
            m_mcause = cause;
            m_mpie = m_mie;
            m_mie = 1'b0;
            m_mpp = 2'b11;
            r.next_pc = m_mtvec;
        end
        if (r.wb.addr == 5'd0) r.wb.we = 1'b0;
        if (r.wb.we) m_regs[r.wb.addr] = r.wb.data;
        m_pc = r.next_pc;
        want = r;
    endtask

    // One instruction in, then wait for its retire handshake.
    task automatic issue(input logic [31:0] w);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!insn_ready_o) begin
            n++;
            if (n > 100) stop_on_error("timeout waiting for insn_ready_o");
            @(negedge clk_i);
        end
        predict(w);
        @(posedge clk_i);
        insn_valid_i <= 1'b1;
        insn_i <= w;
        @(posedge clk_i);
        insn_valid_i <= 1'b0;
        n = 0;
        @(negedge clk_i);
        while (!(retire_valid_o && retire_ready_i)) begin
            n++;
            if (n > 100) stop_on_error("timeout waiting for the retire handshake");
            @(negedge clk_i);
        end
    endtask

    assert property (@(posedge clk_i) disable iff (rst_i)
        retire_valid_o |-> retire_o.pc == want.pc)
        else report_mismatch("retire_o.pc", $sampled(retire_o.pc), $sampled(want.pc));
    assert property (@(posedge clk_i) disable iff (rst_i)
        retire_valid_o |-> retire_o.next_pc == want.next_pc)
        else report_mismatch("retire_o.next_pc", $sampled(retire_o.next_pc),
                             $sampled(want.next_pc));
    assert property (@(posedge clk_i) disable iff (rst_i)
        retire_valid_o |-> retire_o.trap == want.trap)
        else report_mismatch("retire_o.trap", 32'($sampled(retire_o.trap)),
                             32'($sampled(want.trap)));
    assert property (@(posedge clk_i) disable iff (rst_i)
        retire_valid_o |-> retire_o.cause == want.cause)
        else report_mismatch("retire_o.cause", $sampled(retire_o.cause), $sampled(want.cause));
    assert property (@(posedge clk_i) disable iff (rst_i)
        retire_valid_o |-> retire_o.wb.we == want.wb.we && retire_o.wb.addr == want.wb.addr)
        else report_mismatch("retire_o.wb.we/addr", 32'({$sampled(retire_o.wb.we),
                             $sampled(retire_o.wb.addr)}),
                             32'({$sampled(want.wb.we), $sampled(want.wb.addr)}));
    assert property (@(posedge clk_i) disable iff (rst_i)
        retire_valid_o && want.wb.we |-> retire_o.wb.data == want.wb.data)
        else report_mismatch("retire_o.wb.data", $sampled(retire_o.wb.data),
                             $sampled(want.wb.data));
    assert property (@(posedge clk_i) disable iff (rst_i)
        retire_valid_o |-> retire_o.mem.re == want.mem.re && retire_o.mem.we == want.mem.we)
        else report_mismatch("retire_o.mem.re/we", 32'({$sampled(retire_o.mem.re),
                             $sampled(retire_o.mem.we)}),
                             32'({$sampled(want.mem.re), $sampled(want.mem.we)}));
    assert property (@(posedge clk_i) disable iff (rst_i)
        retire_valid_o && (want.mem.re || want.mem.we) |-> retire_o.mem.addr == want.mem.addr)
        else report_mismatch("retire_o.mem.addr", $sampled(retire_o.mem.addr),
                             $sampled(want.mem.addr));
    assert property (@(posedge clk_i) disable iff (rst_i)
        retire_valid_o && want.mem.we |-> retire_o.mem.wdata == want.mem.wdata)
        else report_mismatch("retire_o.mem.wdata", $sampled(retire_o.mem.wdata),
                             $sampled(want.mem.wdata));
    assert property (@(posedge clk_i) disable iff (rst_i)
        retire_valid_o && want.mem.we |-> retire_o.mem.be == want.mem.be)
        else report_mismatch("retire_o.mem.be", 32'($sampled(retire_o.mem.be)),
                             32'($sampled(want.mem.be)));

    // Handshake rules.
    assert property (@(posedge clk_i) disable iff (rst_i)
        retire_valid_o |-> !insn_ready_o)
        else stop_on_error("insn_ready_o high while a retire record is pending");
    assert property (@(posedge clk_i) disable iff (rst_i)
        retire_valid_o && !retire_ready_i |=> retire_valid_o && $stable(retire_o))
        else stop_on_error("retire record changed while retire_ready_i was low");
    assert property (@(posedge clk_i) disable iff (rst_i)
        insn_valid_i && insn_ready_o |=> retire_valid_o)
        else stop_on_error("no retire record one cycle after acceptance");

    initial begin
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = 32'd0;
        end
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        assert (!retire_valid_o && insn_ready_o)
            else stop_on_error("handshake outputs wrong after reset");

        issue(itype(12'h123, 5'd0, 3'd0, 5'd1, 7'h13));
        issue(itype(12'hffb, 5'd1, 3'd0, 5'd2, 7'h13));
        issue(rtype(7'h00, 5'd2, 5'd1, 5'd3));
        issue(rtype(7'h20, 5'd2, 5'd1, 5'd4));
        issue({20'habcde, 5'd5, 7'h37});
        // Writes to x0 are dropped.
        issue(itype(12'h007, 5'd1, 3'd0, 5'd0, 7'h13));
        issue(rtype(7'h00, 5'd1, 5'd0, 5'd6));
        issue(itype(12'h040, 5'd0, 3'd0, 5'd7, 7'h13));
        issue(stype(12'h008, 5'd5, 5'd7));
        issue(itype(12'h008, 5'd7, 3'd2, 5'd8, 7'h03));
        issue(btype(13'd16, 5'd5, 5'd8));
        issue(btype(13'd16, 5'd2, 5'd1));
        issue(jtype(21'h1fffe0, 5'd9));
        issue(itype(12'h200, 5'd0, 3'd0, 5'd10, 7'h13));
        issue(itype(CSR_MTVEC, 5'd10, 3'd1, 5'd11, 7'h73));
        issue(itype(CSR_MTVEC, 5'd10, 3'd1, 5'd12, 7'h73));
        issue(itype(CSR_MSCRATCH, 5'd1, 3'd1, 5'd13, 7'h73));
        // Traps, then return.
        issue(32'hffff_ffff);
        issue(itype(12'h002, 5'd7, 3'd2, 5'd14, 7'h03));
        issue(stype(12'h001, 5'd5, 5'd7));
        issue(32'h3020_0073);
        issue(itype(CSR_MSTATUS, 5'd0, 3'd1, 5'd16, 7'h73));
        issue(itype(CSR_MCAUSE, 5'd0, 3'd1, 5'd18, 7'h73));
        // Set mie, trap, then read back mpie.
        issue(itype(CSR_MSTATUS, 5'd2, 3'd1, 5'd19, 7'h73));
        issue(itype(12'h7c0, 5'd1, 3'd1, 5'd17, 7'h73));
        issue(itype(CSR_MSTATUS, 5'd0, 3'd1, 5'd20, 7'h73));
        @(posedge clk_i);
        @(negedge clk_i);
        $display("TB PASSED");
        $finish;
    end

endmodule
